/* cmd_pkg.sv */
/*
 * Command front end shared definitions: data widths, opcodes,
 * status selectors, SPI timing and FSM encodings.
 */
package cmd_pkg;

	// ------------------------------------------------------------------------
	// data types
	// ------------------------------------------------------------------------
	typedef logic [7:0]  byte_t;       // stream or SPI byte
	typedef logic [63:0] cmd_frame_t;  // byte 0 in the low bits
	typedef logic [31:0] reply_word_t;
	typedef logic [31:0] count_t;      // overrange event count
	typedef logic [2:0]  chip_sel_t;
	typedef logic [1:0]  spi_mode_t;   // CPOL/CPHA

	// ------------------------------------------------------------------------
	// command encoding
	// ------------------------------------------------------------------------
	localparam byte_t OP_STATUS   = 8'd2;
	localparam byte_t OP_SPI      = 8'd3;
	localparam byte_t OP_SPI_MODE = 8'd4;

	// byte 1 of a status command
	localparam byte_t STATUS_VERSION   = 8'd0;
	localparam byte_t STATUS_BOARD     = 8'd1;
	localparam byte_t STATUS_OVERRANGE = 8'd2;

	// byte 7 of an SPI command, anything else means 3 bytes
	localparam byte_t SPI_LEN_SHORT = 8'd2;
	localparam byte_t SPI_LEN_LONG  = 8'd4;

	localparam reply_word_t FIRMWARE_VERSION = 32'd13;

	// ------------------------------------------------------------------------
	// board sizing and SPI timing
	// ------------------------------------------------------------------------
	localparam int N_OVERRANGE = 4;
	localparam int OR_SEL_W    = $clog2(N_OVERRANGE);
	localparam int N_CHIPS     = 8;

	localparam int CS_SETUP_CYCLES = 6;   // cs low before first byte
	localparam int CS_HOLD_CYCLES  = 16;  // cs low after read-back
	localparam int WAIT_W          = $clog2(CS_HOLD_CYCLES);

	// ------------------------------------------------------------------------
	// state machines
	// ------------------------------------------------------------------------
	typedef enum logic {
		RX_COLLECT,
		RX_DISPATCH
	} rx_state_t;

	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_SETUP,    // cs low, settle
		SPI_SEND,     // wait for tx_ready
		SPI_NEXT,     // tx_dv pulse, pick next byte
		SPI_WAIT_RX,
		SPI_HOLD,     // cs still low after read-back
		SPI_REPLY
	} spi_state_t;

endpackage

/* cmd_receiver.sv */
/*
 * Command receiver. Collects 8 stream bytes into a frame and hands it
 * to the handler that owns the opcode, dropping unknown commands.
 */
`timescale 1ns/1ps

module cmd_receiver (
	input  logic                clk,
	input  logic                rstn,
	// byte stream in
	input  logic                i_in_valid,
	input  cmd_pkg::byte_t      i_in_data,
	output logic                o_in_ready,
	// dispatch
	output cmd_pkg::cmd_frame_t o_frame,
	output logic                o_spi_start,
	input  logic                i_spi_ready,
	output logic                o_mode_start,
	output logic                o_status_start,
	input  logic                i_status_ready
);
	import cmd_pkg::*;

	rx_state_t  state;
	logic [2:0] byte_cnt;
	cmd_frame_t frame;
	byte_t      opcode;
	logic       drop;
	logic       in_xfer;

	assign o_in_ready = (state == RX_COLLECT);
	assign in_xfer    = i_in_valid & o_in_ready;
	assign o_frame    = frame;
	assign opcode     = frame[7:0];

	// ------------------------------------------------------------------------
	// frame assembly
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (in_xfer)
			frame <= {i_in_data, frame[63:8]};  // byte 0 ends up lowest
	end

	// ------------------------------------------------------------------------
	// opcode decode, start only while the owner is idle
	// ------------------------------------------------------------------------
	always_comb begin
		o_spi_start    = 1'b0;
		o_mode_start   = 1'b0;
		o_status_start = 1'b0;
		drop           = 1'b0;
		if (state == RX_DISPATCH) begin
			case (opcode)
				OP_STATUS:   o_status_start = i_status_ready;
				OP_SPI:      o_spi_start    = i_spi_ready;
				OP_SPI_MODE: o_mode_start   = i_spi_ready;  // same handler as SPI
				default:     drop           = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state    <= RX_COLLECT;
			byte_cnt <= '0;
		end else begin
			case (state)
				RX_COLLECT: begin
					if (in_xfer) begin
						byte_cnt <= byte_cnt + 3'd1;  // wraps to 0 after byte 7
						if (byte_cnt == 3'd7)
							state <= RX_DISPATCH;
					end
				end
				RX_DISPATCH: begin
					// stays here while the target handler is busy
					if (o_spi_start | o_mode_start | o_status_start | drop)
						state <= RX_COLLECT;
				end
				default: state <= RX_COLLECT;
			endcase
		end
	end

endmodule

/* spi_sequencer.sv */
/*
 * SPI sequencer. Drives the chip-select bank and the external SPI byte
 * master for register transactions, and handles SPI mode changes.
 */
`timescale 1ns/1ps

module spi_sequencer (
	input  logic                              clk,
	input  logic                              rstn,
	input  cmd_pkg::cmd_frame_t               i_frame,
	input  logic                              i_spi_start,
	input  logic                              i_mode_start,
	output logic                              o_ready,
	// SPI byte master
	output cmd_pkg::byte_t                    o_spi_tx,
	output logic                              o_spi_tx_dv,
	input  logic                              i_spi_tx_ready,
	input  cmd_pkg::byte_t                    i_spi_rx,
	input  logic                              i_spi_rx_dv,
	// board pins
	output logic [cmd_pkg::N_CHIPS-1:0]       o_spi_cs,
	output cmd_pkg::chip_sel_t                o_spi_miso_sel,
	output cmd_pkg::spi_mode_t                o_spi_mode,
	output logic                              o_spi_reset_n,
	// reply
	output logic                              o_req,
	output cmd_pkg::reply_word_t              o_reply,
	input  logic                              i_ack
);
	import cmd_pkg::*;

	spi_state_t        state;
	logic [WAIT_W-1:0] wait_cnt;
	logic [1:0]        bytes_left;  // bytes still to send after the current one
	logic [31:0]       tx_data;     // bytes 2..5, current byte in the low bits
	chip_sel_t         chip;
	byte_t             len;

	assign chip     = i_frame[10:8];
	assign len      = i_frame[63:56];
	assign o_spi_tx = tx_data[7:0];
	assign o_ready  = (state == SPI_IDLE);

	// ------------------------------------------------------------------------
	// transaction FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= SPI_IDLE;
			wait_cnt       <= '0;
			bytes_left     <= '0;
			o_spi_tx_dv    <= 1'b0;
			o_spi_cs       <= {N_CHIPS{1'b1}};
			o_spi_miso_sel <= '0;
			o_spi_mode     <= '0;
			o_spi_reset_n  <= 1'b1;
			o_req          <= 1'b0;
		end else begin
			o_spi_tx_dv   <= 1'b0;  // single cycle strobes
			o_spi_reset_n <= 1'b1;
			case (state)
				SPI_IDLE: begin
					wait_cnt <= '0;
					if (i_mode_start) begin
						o_spi_mode    <= i_frame[9:8];
						o_spi_reset_n <= 1'b0;  // restart master in new mode
						o_req         <= 1'b1;
						state         <= SPI_REPLY;
					end else if (i_spi_start) begin
						o_spi_cs       <= ~(N_CHIPS'(1) << chip);
						o_spi_miso_sel <= chip;
						if (len == SPI_LEN_SHORT)
							bytes_left <= 2'd1;
						else if (len == SPI_LEN_LONG)
							bytes_left <= 2'd3;
						else
							bytes_left <= 2'd2;
						state <= SPI_SETUP;
					end
				end
				SPI_SETUP: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == WAIT_W'(CS_SETUP_CYCLES - 1)) begin
						wait_cnt <= '0;
						state    <= SPI_SEND;
					end
				end
				SPI_SEND: begin
					if (i_spi_tx_ready) begin
						o_spi_tx_dv <= 1'b1;
						state       <= SPI_NEXT;
					end
				end
				SPI_NEXT: begin
					if (bytes_left == '0) begin
						state <= SPI_WAIT_RX;
					end else begin
						bytes_left <= bytes_left - 2'd1;
						state      <= SPI_SEND;
					end
				end
				SPI_WAIT_RX: if (i_spi_rx_dv) state <= SPI_HOLD;
				SPI_HOLD: begin
					wait_cnt <= wait_cnt + 1'b1;
					if (wait_cnt == WAIT_W'(CS_HOLD_CYCLES - 1)) begin
						wait_cnt <= '0;
						o_spi_cs <= {N_CHIPS{1'b1}};
						o_req    <= 1'b1;
						state    <= SPI_REPLY;
					end
				end
				SPI_REPLY: begin
					if (i_ack) begin
						o_req <= 1'b0;
						state <= SPI_IDLE;
					end
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// payload
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == SPI_IDLE && i_spi_start)
			tx_data <= i_frame[47:16];
		else if (state == SPI_NEXT && bytes_left != '0)
			tx_data <= tx_data >> 8;  // next byte after the strobe
		if (state == SPI_IDLE && i_mode_start)
			o_reply <= reply_word_t'(i_frame[15:8]);  // echo byte 1
		else if (state == SPI_WAIT_RX && i_spi_rx_dv)
			o_reply <= reply_word_t'(i_spi_rx);
	end

endmodule

/* status_reader.sv */
/*
 * Status reader. Counts ADC overrange events and answers firmware
 * version, board input and counter queries with one reply word.
 */
`timescale 1ns/1ps

module status_reader (
	input  logic                            clk,
	input  logic                            rstn,
	input  cmd_pkg::cmd_frame_t             i_frame,
	input  logic                            i_start,
	output logic                            o_ready,
	input  cmd_pkg::byte_t                  i_board_in,
	input  logic [cmd_pkg::N_OVERRANGE-1:0] i_overrange,
	output logic                            o_req,
	output cmd_pkg::reply_word_t            o_reply,
	input  logic                            i_ack
);
	import cmd_pkg::*;

	count_t              or_count [N_OVERRANGE];
	byte_t               sel;
	logic [OR_SEL_W-1:0] or_idx;

	assign sel     = i_frame[15:8];            // byte 1
	assign or_idx  = i_frame[16 +: OR_SEL_W];  // low bits of byte 2
	assign o_ready = ~o_req;

	// one count per cycle the overrange flag is up
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < N_OVERRANGE; i++)
				or_count[i] <= '0;
		end else begin
			for (int i = 0; i < N_OVERRANGE; i++)
				if (i_overrange[i])
					or_count[i] <= or_count[i] + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			o_req <= 1'b0;
		else if (i_start)
			o_req <= 1'b1;
		else if (i_ack)
			o_req <= 1'b0;
	end

	// answer is frozen at start
	always_ff @(posedge clk) begin
		if (i_start) begin
			case (sel)
				STATUS_VERSION:   o_reply <= FIRMWARE_VERSION;
				STATUS_BOARD:     o_reply <= {4{i_board_in}};
				STATUS_OVERRANGE: o_reply <= or_count[or_idx];
				default:          o_reply <= '0;
			endcase
		end
	end

endmodule

/* reply_arbiter.sv */
/*
 * Reply arbiter. Round-robin choice between the SPI and status
 * handlers, one registered word at a time on the output stream.
 */
`timescale 1ns/1ps

module reply_arbiter (
	input  logic                 clk,
	input  logic                 rstn,
	// handlers
	input  logic                 i_spi_req,
	input  cmd_pkg::reply_word_t i_spi_reply,
	output logic                 o_spi_ack,
	input  logic                 i_status_req,
	input  cmd_pkg::reply_word_t i_status_reply,
	output logic                 o_status_ack,
	// reply stream out
	output logic                 o_out_valid,
	output cmd_pkg::reply_word_t o_out_data,
	input  logic                 i_out_ready
);
	import cmd_pkg::*;

	logic        last_status;   // status won the last grant and owns the output word
	logic        pick_status;
	logic        out_xfer;
	reply_word_t win_reply;

	// status wins unless spi also asks and status had the previous turn
	assign pick_status = i_status_req & (~i_spi_req | ~last_status);
	assign win_reply   = pick_status ? i_status_reply : i_spi_reply;
	assign out_xfer    = o_out_valid & i_out_ready;

	assign o_spi_ack    = out_xfer & ~last_status;
	assign o_status_ack = out_xfer & last_status;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_out_valid <= 1'b0;
			last_status <= 1'b0;
		end else if (!o_out_valid) begin
			if (i_spi_req | i_status_req) begin
				o_out_valid <= 1'b1;
				last_status <= pick_status;
			end
		end else if (i_out_ready) begin
			o_out_valid <= 1'b0;  // owner drops req on the same edge
		end
	end

	always_ff @(posedge clk) begin
		if (!o_out_valid && (i_spi_req || i_status_req))
			o_out_data <= win_reply;
	end

endmodule

/* cmd_processor.sv */
/*
 * Command processor top level. Byte command stream in, one reply word
 * per command out, SPI chip access and status readback in between.
 */
`timescale 1ns/1ps

module cmd_processor (
	input  logic                            clk,
	input  logic                            rstn,
	// command byte stream
	input  logic                            i_in_valid,
	input  cmd_pkg::byte_t                  i_in_data,
	output logic                            o_in_ready,
	// reply stream
	output logic                            o_out_valid,
	output cmd_pkg::reply_word_t            o_out_data,
	input  logic                            i_out_ready,
	// SPI byte master
	output cmd_pkg::byte_t                  o_spi_tx,
	output logic                            o_spi_tx_dv,
	input  logic                            i_spi_tx_ready,
	input  cmd_pkg::byte_t                  i_spi_rx,
	input  logic                            i_spi_rx_dv,
	// board pins
	output logic [cmd_pkg::N_CHIPS-1:0]     o_spi_cs,
	output cmd_pkg::chip_sel_t              o_spi_miso_sel,
	output cmd_pkg::spi_mode_t              o_spi_mode,
	output logic                            o_spi_reset_n,
	input  cmd_pkg::byte_t                  i_board_in,
	input  logic [cmd_pkg::N_OVERRANGE-1:0] i_overrange
);
	import cmd_pkg::*;

	cmd_frame_t  frame;
	logic        spi_start, mode_start, spi_ready;
	logic        status_start, status_ready;
	logic        spi_req, spi_ack, status_req, status_ack;
	reply_word_t spi_reply, status_reply;

	// ------------------------------------------------------------------------
	// command intake
	// ------------------------------------------------------------------------
	cmd_receiver u_receiver (
		.clk(clk), .rstn(rstn),
		.i_in_valid(i_in_valid), .i_in_data(i_in_data), .o_in_ready(o_in_ready),
		.o_frame(frame),
		.o_spi_start(spi_start), .i_spi_ready(spi_ready), .o_mode_start(mode_start),
		.o_status_start(status_start), .i_status_ready(status_ready)
	);

	// ------------------------------------------------------------------------
	// handlers
	// ------------------------------------------------------------------------
	spi_sequencer u_spi (
		.clk(clk), .rstn(rstn), .i_frame(frame),
		.i_spi_start(spi_start), .i_mode_start(mode_start), .o_ready(spi_ready),
		.o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv), .i_spi_tx_ready(i_spi_tx_ready),
		.i_spi_rx(i_spi_rx), .i_spi_rx_dv(i_spi_rx_dv),
		.o_spi_cs(o_spi_cs), .o_spi_miso_sel(o_spi_miso_sel),
		.o_spi_mode(o_spi_mode), .o_spi_reset_n(o_spi_reset_n),
		.o_req(spi_req), .o_reply(spi_reply), .i_ack(spi_ack)
	);

	status_reader u_status (
		.clk(clk), .rstn(rstn), .i_frame(frame),
		.i_start(status_start), .o_ready(status_ready),
		.i_board_in(i_board_in), .i_overrange(i_overrange),
		.o_req(status_req), .o_reply(status_reply), .i_ack(status_ack)
	);

	// shared reply path
	reply_arbiter u_arbiter (
		.clk(clk), .rstn(rstn),
		.i_spi_req(spi_req), .i_spi_reply(spi_reply), .o_spi_ack(spi_ack),
		.i_status_req(status_req), .i_status_reply(status_reply),
		.o_status_ack(status_ack),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data), .i_out_ready(i_out_ready)
	);

endmodule

/* cmd_processor_assertions.sv */
/*
 * Protocol checks on the command processor: reply stream stability
 * and chip-select use during SPI transfers.
 */
`timescale 1ns/1ps

module cmd_processor_assertions (
	input logic                        clk,
	input logic                        rstn,
	input logic                        o_out_valid,
	input logic                        i_out_ready,
	input cmd_pkg::reply_word_t        o_out_data,
	input logic [cmd_pkg::N_CHIPS-1:0] o_spi_cs,
	input logic                        o_spi_tx_dv
);

	int fails = 0;  // failed assertion count

	// stalled word must not move
	assert property (@(posedge clk) disable iff (!rstn)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data))
		else begin
			fails++;
			$error("reply word changed while stalled");
		end

	assert property (@(posedge clk) disable iff (!rstn) $onehot0(~o_spi_cs))
		else begin
			fails++;
			$error("more than one chip select low");
		end

	assert property (@(posedge clk) disable iff (!rstn)
		o_spi_tx_dv |-> (o_spi_cs != '1))
		else begin
			fails++;
			$error("SPI byte sent with no chip selected");
		end

endmodule

bind cmd_processor cmd_processor_assertions u_assertions (
	.clk(clk), .rstn(rstn),
	.o_out_valid(o_out_valid), .i_out_ready(i_out_ready), .o_out_data(o_out_data),
	.o_spi_cs(o_spi_cs), .o_spi_tx_dv(o_spi_tx_dv)
);

/* cmd_processor_tb.sv */
/*
 * Command processor testbench. Table of commands applied in a loop,
 * with an SPI master model, overrange stimulus and a back-pressure test.
 */
`timescale 1ns/1ps

module cmd_processor_tb;
	import cmd_pkg::*;

	localparam int NROWS = 13;
	localparam int LIMIT = 400 * (NROWS + 2);  // 400 cycles per row

	logic clk, rstn, i_in_valid, o_in_ready, o_out_valid, i_out_ready;
	logic o_spi_tx_dv, i_spi_tx_ready, i_spi_rx_dv, o_spi_reset_n;
	byte_t i_in_data, o_spi_tx, i_spi_rx, i_board_in;
	reply_word_t o_out_data;
	logic [N_CHIPS-1:0] o_spi_cs;
	chip_sel_t o_spi_miso_sel;
	spi_mode_t o_spi_mode;
	logic [N_OVERRANGE-1:0] i_overrange;

	logic [31:0] rng = 32'ha40e;
	int errors, cycles, nrows, reset_pulses, tx_timer, rx_timer;
	bit quiet, bp_en, rx_hold, rx_pend;
	count_t or_cnt [N_OVERRANGE];
	byte_t last_rx;
	byte_t spi_bytes [$];
	logic [N_CHIPS-1:0] spi_cs [$];
	reply_word_t replies [$];
	string t_name [NROWS];
	cmd_frame_t t_frame [NROWS];
	bit t_reply [NROWS];

	cmd_processor DUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// ------------------------------------------------------------------------
	// overrange stimulus, output back-pressure, reply capture
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		logic [31:0] r;
		r = next_rand();
		if (rstn) begin
			for (int i = 0; i < N_OVERRANGE; i++)
				if (i_overrange[i])
					or_cnt[i] = or_cnt[i] + 1;
			if (!o_spi_reset_n)
				reset_pulses++;
		end
		if (o_out_valid && i_out_ready)
			replies.push_back(o_out_data);
		i_overrange <= quiet ? '0 : r[3:0];  // frozen while a status read runs
		i_out_ready <= !bp_en || (r[9:8] != 2'b00);
	end

	// ------------------------------------------------------------------------
	// SPI byte master model
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		logic [31:0] r;
		r = next_rand();
		i_spi_rx_dv <= 1'b0;
		if (o_spi_tx_dv) begin
			spi_bytes.push_back(o_spi_tx);
			spi_cs.push_back(o_spi_cs);
			i_spi_tx_ready <= 1'b0;
			tx_timer = int'(r[1:0]);
			rx_timer = 2 + int'(r[4:2]);  // each byte restarts the rx delay
			rx_pend = 1'b1;
		end else begin
			if (!i_spi_tx_ready) begin
				if (tx_timer == 0)
					i_spi_tx_ready <= 1'b1;
				else
					tx_timer--;
			end
			if (rx_pend && !rx_hold) begin
				if (rx_timer == 0) begin
					last_rx = r[15:8];
					i_spi_rx <= r[15:8];
					i_spi_rx_dv <= 1'b1;
					rx_pend = 1'b0;
				end else begin
					rx_timer--;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// helpers and checks
	// ------------------------------------------------------------------------
	function automatic cmd_frame_t make_frame(byte_t b0, b1, b2, b3, b4, b5, b6, b7);
		return {b7, b6, b5, b4, b3, b2, b1, b0};
	endfunction

	task automatic add_row(string name, cmd_frame_t f, bit has_reply);
		t_name[nrows] = name;
		t_frame[nrows] = f;
		t_reply[nrows] = has_reply;
		nrows++;
	endtask

	// expected reply from the command rules
	function automatic reply_word_t expect_reply(cmd_frame_t f);
		if (f[7:0] == 8'd3)
			return {24'd0, last_rx};
		if (f[7:0] == 8'd4)
			return {24'd0, f[15:8]};
		case (f[15:8])
			8'd0:    return 32'd13;
			8'd1:    return {4{i_board_in}};
			8'd2:    return or_cnt[f[17:16]];
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_reply(string name, reply_word_t exp, reply_word_t act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_spi_byte(string name, byte_t exp, byte_t act);
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	// called right after a rising edge
	task automatic send_frame(cmd_frame_t f);
		for (int k = 0; k < 8; k++) begin
			i_in_valid <= 1'b1;
			i_in_data <= f[k*8 +: 8];
			do @(posedge clk); while (!o_in_ready);
		end
		i_in_valid <= 1'b0;
	endtask

	task automatic wait_replies(int n);
		while (replies.size() < n)
			@(posedge clk);
	endtask

	task automatic start_cmd(bit is_status);
		logic [31:0] r;
		r = next_rand();
		quiet = is_status;
		repeat (3) @(posedge clk);  // let the zero pattern reach the counters
		spi_bytes.delete();
		spi_cs.delete();
		replies.delete();
		i_board_in <= r[7:0];
	endtask

	task automatic run_row(int i);
		cmd_frame_t f;
		int n, pulses;
		f = t_frame[i];
		n = (f[63:56] == 8'd2) ? 2 : (f[63:56] == 8'd4) ? 4 : 3;
		pulses = reset_pulses;
		start_cmd(f[7:0] == 8'd2);
		send_frame(f);
		if (t_reply[i]) begin
			wait_replies(1);
			check_reply(t_name[i], expect_reply(f), replies[0]);
		end else begin
			repeat (60) @(posedge clk);
			if (replies.size() != 0) begin
				errors++;
				$display("%s: a reply came back for a command that should be dropped", t_name[i]);
			end
		end
		if (f[7:0] == 8'd3) begin
			check_spi_byte({t_name[i], " miso sel"}, {5'd0, f[10:8]}, {5'd0, o_spi_miso_sel});
			check_spi_byte({t_name[i], " cs release"}, 8'hff, o_spi_cs);
			if (spi_bytes.size() != n) begin
				errors++;
				$display("%s: SPI master got %0d bytes instead of %0d", t_name[i],
					spi_bytes.size(), n);
			end else begin
				for (int k = 0; k < n; k++) begin
					check_spi_byte({t_name[i], " tx"}, f[(2+k)*8 +: 8], spi_bytes[k]);
					check_spi_byte({t_name[i], " cs"}, ~(8'd1 << f[10:8]), spi_cs[k]);
				end
			end
		end
		if (f[7:0] == 8'd4) begin
			check_spi_byte({t_name[i], " mode"}, {6'd0, f[9:8]}, {6'd0, o_spi_mode});
			check_reply({t_name[i], " reset pulse"}, 32'd1, reply_word_t'(reset_pulses - pulses));
		end
		quiet = 1'b0;
	endtask

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped answering", cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		errors = 0;
		nrows = 0;
		reset_pulses = 0;
		{quiet, bp_en, rx_hold, rx_pend} = '0;
		for (int i = 0; i < N_OVERRANGE; i++)
			or_cnt[i] = '0;
		rstn = 1'b0;
		{i_in_valid, i_in_data, i_spi_rx, i_spi_rx_dv, i_board_in, i_overrange} = '0;
		i_out_ready = 1'b1;
		i_spi_tx_ready = 1'b1;

		add_row("version", make_frame(2, 0, 0, 0, 0, 0, 0, 0), 1);
		add_row("board input", make_frame(2, 1, 0, 0, 0, 0, 0, 0), 1);
		for (int k = 0; k < N_OVERRANGE; k++)
			add_row($sformatf("overrange %0d", k), make_frame(2, 2, byte_t'(k), 0, 0, 0, 0, 0), 1);
		add_row("spi 2 bytes", make_frame(3, 5, 8'ha1, 8'hb2, 8'hc3, 8'hd4, 0, 2), 1);
		add_row("spi 3 bytes", make_frame(3, 0, 8'h11, 8'h22, 8'h33, 8'h44, 0, 0), 1);
		add_row("spi 4 bytes", make_frame(3, 7, 8'h5a, 8'h6b, 8'h7c, 8'h8d, 0, 4), 1);
		add_row("spi mode 2", make_frame(4, 2, 0, 0, 0, 0, 0, 0), 1);
		add_row("unknown opcode", make_frame(9, 0, 0, 0, 0, 0, 0, 0), 0);
		add_row("version after drop", make_frame(2, 0, 0, 0, 0, 0, 0, 0), 1);
		add_row("spi mode 3", make_frame(4, 8'h07, 0, 0, 0, 0, 0, 0), 1);

		repeat (10) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < nrows; i++)
			run_row(i);

		// status command overtakes a stalled SPI transaction
		rx_hold = 1'b1;
		bp_en = 1'b1;
		start_cmd(1'b1);
		send_frame(make_frame(3, 2, 8'h01, 8'h02, 8'h03, 8'h04, 0, 4));
		send_frame(make_frame(2, 1, 0, 0, 0, 0, 0, 0));
		wait_replies(1);
		check_reply("overlap status", {4{i_board_in}}, replies[0]);
		rx_hold = 1'b0;
		wait_replies(2);
		check_reply("overlap spi", {24'd0, last_rx}, replies[1]);
		bp_en = 1'b0;
		quiet = 1'b0;
		repeat (5) @(posedge clk);

		$display("%0d rows plus overlap run, %0d errors, %0d assertion failures", nrows, errors,
			DUT.u_assertions.fails);
		if (errors == 0 && DUT.u_assertions.fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sim.f */
cmd_pkg.sv
cmd_receiver.sv
spi_sequencer.sv
status_reader.sv
reply_arbiter.sv
cmd_processor.sv
cmd_processor_assertions.sv
cmd_processor_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the command processor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module cmd_processor_tb -f sim.f -o sim_bin > build.log 2>&1 \
	&& ./obj_dir/sim_bin > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && exit 0 || { echo "simulation failed, see build.log and sim.log"; exit 1; }
